// File: tlb_macros.svh
// tlb and page table sizes
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// address and field widths
`define TLB_VA_BITS      32
`define TLB_OFFSET_BITS  12
`define TLB_PPN_BITS     22
`define TLB_ASID_BITS    9
`define TLB_PA_BITS      34

// tlb geometry
`define TLB_SIZE         16
`define TLB_ASSOC        2
`define TLB_SETS         (`TLB_SIZE / `TLB_ASSOC)
`define TLB_SET_BITS     $clog2(`TLB_SETS)
`define TLB_WAY_BITS     $clog2(`TLB_ASSOC)
`define TLB_VPN_BITS     (`TLB_VA_BITS - `TLB_OFFSET_BITS)
`define TLB_TAG_BITS     (`TLB_VPN_BITS - `TLB_SET_BITS)

// flat page table
`define PT_INDEX_BITS    6
`define PT_ENTRIES       (1 << `PT_INDEX_BITS)
`define PT_LATENCY       3

`endif

// File: tlb_pkg.sv
// tlb types
`include "tlb_macros.svh"

package tlb_pkg;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        HIT,
        FETCH,
        FENCE_TLB
    } tlb_state_e;

    // kind of access being translated
    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE,
        INSN
    } access_e;

    typedef struct packed {
        logic [1:0] reserved;
        logic       dirty;
        logic       accessed;
        logic       global_page;
        logic       user;
        logic       executable;
        logic       writable;
        logic       readable;
        logic       valid;
    } pte_perms_t;

    // sv32 leaf pte
    typedef struct packed {
        logic [`TLB_PPN_BITS-1:0] ppn;
        pte_perms_t               perms;
    } pte_t;

    typedef struct packed {
        logic                      valid;
        logic [`TLB_ASID_BITS-1:0] asid;
        logic [`TLB_TAG_BITS-1:0]  vpn_tag; // vpn bits above the set index
    } tlb_tag_t;

    typedef struct packed {
        tlb_tag_t tag;
        pte_t     pte;
    } tlb_frame_t;

    // one ram row
    typedef struct packed {
        tlb_frame_t [`TLB_ASSOC-1:0] frames;
    } tlb_set_t;

endpackage

// File: tlb_bus_if.sv
// page table request bus
`timescale 1ns/1ps
`include "tlb_macros.svh"

interface tlb_bus_if;

    logic [`TLB_VA_BITS-1:0] addr;
    logic                    ren;
    logic                    wen;
    tlb_pkg::pte_t           rdata; // valid in the cycle busy is low
    logic                    busy;

    // requester side
    modport cpu (
        output addr,
        output ren,
        output wen,
        input  rdata,
        input  busy
    );

    // responder side
    modport target (
        input  addr,
        input  ren,
        input  wen,
        output rdata,
        output busy
    );

endinterface

// File: tlb_set_ram.sv
// tlb set array
`timescale 1ns/1ps
`include "tlb_macros.svh"

module tlb_set_ram (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic [`TLB_SET_BITS-1:0] sel,
    input  logic                     wen,
    input  tlb_pkg::tlb_set_t        wdata,
    input  tlb_pkg::tlb_set_t        wmask,
    output tlb_pkg::tlb_set_t        rdata
);

    tlb_pkg::tlb_set_t rows [`TLB_SETS];

    // async read of the selected set
    assign rdata = rows[sel];

    // a zero mask bit takes the new value, a one keeps the old bit
    always_ff @(posedge CLK) begin
        if (nRST && wen) begin // no writes while reset is held
            rows[sel] <= (rows[sel] & wmask) | (wdata & ~wmask);
        end
    end

endmodule

// File: page_perm_check.sv
// sv32 page permission check
`timescale 1ns/1ps

module page_perm_check (
    input  logic              check,
    input  tlb_pkg::access_e  access,
    input  tlb_pkg::pte_t     pte,
    input  logic              user_mode,
    output logic              fault_load_page,
    output logic              fault_store_page,
    output logic              fault_insn_page
);

    logic base_fault;
    logic need_fault;
    logic any_fault;

    // faults that apply to every access type
    assign base_fault = !pte.perms.valid ||
                        (pte.perms.writable && !pte.perms.readable) || // reserved encoding
                        (pte.perms.user != user_mode);

    // permission the access itself needs
    always_comb begin
        need_fault = 1'b0;
        case (access)
            tlb_pkg::LOAD:  need_fault = !pte.perms.readable;
            tlb_pkg::STORE: need_fault = !pte.perms.writable;
            tlb_pkg::INSN:  need_fault = !pte.perms.executable;
            default:        need_fault = 1'b0;
        endcase
    end

    assign any_fault = check && (base_fault || need_fault);

    // route to the matching fault line
    assign fault_load_page  = any_fault && (access == tlb_pkg::LOAD);
    assign fault_store_page = any_fault && (access == tlb_pkg::STORE);
    assign fault_insn_page  = any_fault && (access == tlb_pkg::INSN);

endmodule

// File: tlb.sv
// set-associative tlb controller
`timescale 1ns/1ps
`include "tlb_macros.svh"

module tlb (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [`TLB_VA_BITS-1:0]   req_addr,
    input  logic                      req_ren,
    input  logic                      req_wen,
    input  logic                      req_exec,
    input  logic [`TLB_ASID_BITS-1:0] satp_asid,
    input  logic                      user_mode,
    input  logic                      addr_trans_on,
    input  logic                      fence,
    input  logic [`TLB_VA_BITS-1:0]   fence_va,
    input  logic [`TLB_ASID_BITS-1:0] fence_asid,
    output logic                      req_busy,
    output logic [`TLB_PA_BITS-1:0]   resp_pa,
    output logic                      tlb_miss,
    output logic                      fence_done,
    output logic                      fault_load_page,
    output logic                      fault_store_page,
    output logic                      fault_insn_page,
    tlb_bus_if.cpu                    mem_bus
);

    localparam int SWEEP_BITS = `TLB_SET_BITS + `TLB_WAY_BITS;

    tlb_pkg::tlb_state_e state, next_state;
    logic [SWEEP_BITS-1:0]     sweep_cnt, next_sweep_cnt; // {set, way}
    logic [`TLB_SETS-1:0]      last_used, next_last_used; // one way bit per set

    // request fields
    logic [`TLB_SET_BITS-1:0]    req_set;
    logic [`TLB_TAG_BITS-1:0]    req_tag;
    logic [`TLB_OFFSET_BITS-1:0] req_offset;
    logic                        req_any;
    tlb_pkg::access_e            access;

    // sweep position and fence match
    logic [`TLB_SET_BITS-1:0] sweep_set;
    logic [`TLB_WAY_BITS-1:0] sweep_way;
    tlb_pkg::tlb_frame_t      sweep_frame;
    logic                     fence_match;

    // set array port
    logic [`TLB_SET_BITS-1:0] ram_sel;
    logic                     ram_wen;
    tlb_pkg::tlb_set_t        ram_wdata, ram_wmask, ram_rdata;

    // lookup
    logic                     hit, hit_ok;
    logic [`TLB_WAY_BITS-1:0] hit_way, victim;
    tlb_pkg::pte_t            hit_pte;

    assign req_offset = req_addr[`TLB_OFFSET_BITS-1:0];
    assign req_set    = req_addr[`TLB_OFFSET_BITS +: `TLB_SET_BITS];
    assign req_tag    = req_addr[`TLB_VA_BITS-1 -: `TLB_TAG_BITS];
    assign req_any    = req_ren | req_wen | req_exec;

    // store wins, then fetch, then load
    assign access = req_wen  ? tlb_pkg::STORE :
                    req_exec ? tlb_pkg::INSN  :
                    req_ren  ? tlb_pkg::LOAD  : tlb_pkg::NONE;

    assign sweep_set   = sweep_cnt[SWEEP_BITS-1 -: `TLB_SET_BITS];
    assign sweep_way   = sweep_cnt[`TLB_WAY_BITS-1:0];
    assign sweep_frame = ram_rdata.frames[sweep_way];

    // page match (or no va given) and asid match on non-global (or no asid given)
    assign fence_match = sweep_frame.tag.valid &&
        (fence_va == '0 ||
         {sweep_frame.tag.vpn_tag, sweep_set} == fence_va[`TLB_VA_BITS-1:`TLB_OFFSET_BITS]) &&
        (fence_asid == '0 ||
         (sweep_frame.tag.asid == fence_asid && !sweep_frame.pte.perms.global_page));

    assign ram_sel = (state == tlb_pkg::IDLE || state == tlb_pkg::FENCE_TLB) ? sweep_set
                                                                             : req_set;

    tlb_set_ram i_tlb_set_ram (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (ram_sel),
        .wen   (ram_wen),
        .wdata (ram_wdata),
        .wmask (ram_wmask),
        .rdata (ram_rdata)
    );

    // tag compare across the ways
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        hit_pte = '0;
        for (int i = 0; i < `TLB_ASSOC; i++) begin
            if (ram_rdata.frames[i].tag.valid &&
                ram_rdata.frames[i].tag.asid == satp_asid &&
                ram_rdata.frames[i].tag.vpn_tag == req_tag) begin
                hit     = 1'b1;
                hit_way = i[`TLB_WAY_BITS-1:0];
                hit_pte = ram_rdata.frames[i].pte;
            end
        end
    end

    assign hit_ok = (state == tlb_pkg::HIT) && !fence && req_any && addr_trans_on && hit;
    assign victim = ~last_used[req_set]; // the way not used last

    page_perm_check i_page_perm_check (
        .check            (hit_ok),
        .access           (access),
        .pte              (hit_pte),
        .user_mode        (user_mode),
        .fault_load_page  (fault_load_page),
        .fault_store_page (fault_store_page),
        .fault_insn_page  (fault_insn_page)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= tlb_pkg::IDLE;
            sweep_cnt <= '0;
            last_used <= '0;
        end else begin
            state     <= next_state;
            sweep_cnt <= next_sweep_cnt;
            last_used <= next_last_used;
        end
    end

    always_comb begin
        next_state     = state;
        next_sweep_cnt = sweep_cnt;
        next_last_used = last_used;
        ram_wen        = 1'b0;
        ram_wdata      = '0;
        ram_wmask      = '1;
        req_busy       = 1'b1;
        resp_pa        = `TLB_PA_BITS'(req_addr);
        tlb_miss       = 1'b0;
        fence_done     = 1'b0;
        mem_bus.addr   = req_addr;
        mem_bus.ren    = 1'b0;
        mem_bus.wen    = 1'b0; // pte fetches only read

        case (state)
            tlb_pkg::IDLE: begin
                // invalidate a whole set per cycle
                ram_wen        = 1'b1;
                ram_wmask      = '0;
                next_sweep_cnt = {sweep_set + 1'b1, sweep_way};
                if (&sweep_set) begin
                    next_state = tlb_pkg::HIT;
                end
            end
            tlb_pkg::HIT: begin
                if (fence) begin
                    next_state = tlb_pkg::FENCE_TLB;
                end else if (req_any && !addr_trans_on) begin
                    req_busy = 1'b0; // pass through
                end else if (hit_ok) begin
                    req_busy                = 1'b0;
                    resp_pa                 = {hit_pte.ppn, req_offset};
                    next_last_used[req_set] = hit_way;
                end else if (req_any) begin
                    tlb_miss   = 1'b1;
                    next_state = tlb_pkg::FETCH;
                end
            end
            tlb_pkg::FETCH: begin
                tlb_miss    = 1'b1;
                mem_bus.ren = 1'b1;
                if (!mem_bus.busy) begin
                    // fill the victim, lookup is retried from HIT
                    ram_wen                              = 1'b1;
                    ram_wdata.frames[victim].tag.valid   = 1'b1;
                    ram_wdata.frames[victim].tag.asid    = satp_asid;
                    ram_wdata.frames[victim].tag.vpn_tag = req_tag;
                    ram_wdata.frames[victim].pte         = mem_bus.rdata;
                    ram_wmask.frames[victim]             = '0;
                    next_last_used[req_set]              = victim;
                    next_state                           = tlb_pkg::HIT;
                end
            end
            tlb_pkg::FENCE_TLB: begin
                // one frame per cycle
                next_sweep_cnt = sweep_cnt + 1'b1;
                if (fence_match) begin
                    ram_wen                     = 1'b1;
                    ram_wmask.frames[sweep_way] = '0;
                end
                if (&sweep_cnt) begin
                    fence_done = 1'b1;
                    next_state = tlb_pkg::HIT;
                end
            end
        endcase
    end

endmodule

// File: page_table_mem.sv
// flat page table memory
`timescale 1ns/1ps
`include "tlb_macros.svh"

module page_table_mem (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      pt_we,
    input  logic [`PT_INDEX_BITS-1:0] pt_index,
    input  tlb_pkg::pte_t             pt_pte,
    tlb_bus_if.target                 bus
);

    localparam int CNT_BITS = $clog2(`PT_LATENCY + 1);

    tlb_pkg::pte_t             ptes [`PT_ENTRIES];
    logic [CNT_BITS-1:0]       wait_cnt; // cycles spent on the current request
    logic [`PT_INDEX_BITS-1:0] rd_index;
    logic                      req;
    logic                      done;

    assign req      = bus.ren | bus.wen;
    assign rd_index = bus.addr[`TLB_OFFSET_BITS +: `PT_INDEX_BITS]; // low vpn bits
    assign done     = req && (wait_cnt == CNT_BITS'(`PT_LATENCY));

    assign bus.busy  = !done;
    assign bus.rdata = ptes[rd_index];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
            for (int i = 0; i < `PT_ENTRIES; i++) begin
                ptes[i] <= '0;
            end
        end else begin
            if (pt_we) begin
                ptes[pt_index] <= pt_pte;
            end
            if (!req || done) begin
                wait_cnt <= '0; // re-arm for the next request
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

endmodule

// File: tlb_top.sv
// address translation top level
`timescale 1ns/1ps
`include "tlb_macros.svh"

module tlb_top (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [`TLB_VA_BITS-1:0]   req_addr,
    input  logic                      req_ren,
    input  logic                      req_wen,
    input  logic                      req_exec,
    input  logic [`TLB_ASID_BITS-1:0] satp_asid,
    input  logic                      user_mode,
    input  logic                      addr_trans_on,
    output logic                      req_busy,
    output logic [`TLB_PA_BITS-1:0]   resp_pa,
    output logic                      tlb_miss,
    output logic                      fault_load_page,
    output logic                      fault_store_page,
    output logic                      fault_insn_page,
    input  logic                      fence,
    input  logic [`TLB_VA_BITS-1:0]   fence_va,
    input  logic [`TLB_ASID_BITS-1:0] fence_asid,
    output logic                      fence_done,
    input  logic                      pt_we,
    input  logic [`PT_INDEX_BITS-1:0] pt_index,
    input  tlb_pkg::pte_t             pt_pte
);

    tlb_bus_if mem_bus ();

    tlb i_tlb (
        .CLK              (CLK),
        .nRST             (nRST),
        .req_addr         (req_addr),
        .req_ren          (req_ren),
        .req_wen          (req_wen),
        .req_exec         (req_exec),
        .satp_asid        (satp_asid),
        .user_mode        (user_mode),
        .addr_trans_on    (addr_trans_on),
        .fence            (fence),
        .fence_va         (fence_va),
        .fence_asid       (fence_asid),
        .req_busy         (req_busy),
        .resp_pa          (resp_pa),
        .tlb_miss         (tlb_miss),
        .fence_done       (fence_done),
        .fault_load_page  (fault_load_page),
        .fault_store_page (fault_store_page),
        .fault_insn_page  (fault_insn_page),
        .mem_bus          (mem_bus.cpu)
    );

    page_table_mem i_page_table_mem (
        .CLK      (CLK),
        .nRST     (nRST),
        .pt_we    (pt_we),
        .pt_index (pt_index),
        .pt_pte   (pt_pte),
        .bus      (mem_bus.target)
    );

endmodule

// File: tb_tlb_top.sv
// tlb subsystem testbench
`timescale 1ns/1ps
`include "tlb_macros.svh"

module tb_tlb_top;

    localparam int TIMEOUT = 50; // cycles allowed per wait
    localparam int SEED    = 83589;

    // test pages whose low vpn bits pick the page table entry
    localparam logic [31:0] VA_RWX = 32'h8040_1a3c; // entry 1, set 1
    localparam logic [31:0] VA_RO  = 32'h0000_2010; // entry 2
    localparam logic [31:0] VA_XO  = 32'h0000_3ff8; // entry 3
    localparam logic [31:0] VA_INV = 32'h0000_4100; // entry 4
    localparam logic [31:0] VA_USR = 32'h0000_5004; // entry 5
    localparam logic [31:0] VA_GLB = 32'h0000_6abc; // entry 6
    localparam logic [31:0] VA_A   = 32'h0000_7000; // entries 7, 15, 23 share set 7
    localparam logic [31:0] VA_B   = 32'h0000_f000;
    localparam logic [31:0] VA_C   = 32'h0001_7000;

    logic                      CLK;
    logic                      nRST;
    logic [`TLB_VA_BITS-1:0]   req_addr;
    logic                      req_ren, req_wen, req_exec;
    logic [`TLB_ASID_BITS-1:0] satp_asid;
    logic                      user_mode, addr_trans_on;
    logic                      req_busy;
    logic [`TLB_PA_BITS-1:0]   resp_pa;
    logic                      tlb_miss;
    logic                      fault_load_page, fault_store_page, fault_insn_page;
    logic                      fence;
    logic [`TLB_VA_BITS-1:0]   fence_va;
    logic [`TLB_ASID_BITS-1:0] fence_asid;
    logic                      fence_done;
    logic                      pt_we;
    logic [`PT_INDEX_BITS-1:0] pt_index;
    tlb_pkg::pte_t             pt_pte;

    tlb_pkg::pte_t shadow [`PT_ENTRIES]; // what the page table holds
    int            n_checks, n_errors, n_tests, test_errors, done_count;
    string         test_name;

    tlb_top i_tlb_top (
        .CLK              (CLK),
        .nRST             (nRST),
        .req_addr         (req_addr),
        .req_ren          (req_ren),
        .req_wen          (req_wen),
        .req_exec         (req_exec),
        .satp_asid        (satp_asid),
        .user_mode        (user_mode),
        .addr_trans_on    (addr_trans_on),
        .req_busy         (req_busy),
        .resp_pa          (resp_pa),
        .tlb_miss         (tlb_miss),
        .fault_load_page  (fault_load_page),
        .fault_store_page (fault_store_page),
        .fault_insn_page  (fault_insn_page),
        .fence            (fence),
        .fence_va         (fence_va),
        .fence_asid       (fence_asid),
        .fence_done       (fence_done),
        .pt_we            (pt_we),
        .pt_index         (pt_index),
        .pt_pte           (pt_pte)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // fence_done only changes after a rising edge
    always @(negedge CLK) begin
        if (fence_done) begin
            done_count++;
        end
    end

    // at most one fault line and never while busy
    always @(negedge CLK) begin
        #1;
        if (nRST) begin
            assert ((({fault_load_page, fault_store_page, fault_insn_page} &
                      ({fault_load_page, fault_store_page, fault_insn_page} - 3'd1)) == 3'd0) &&
                    !(req_busy && (fault_load_page || fault_store_page || fault_insn_page)))
            else begin
                $display("fault lines invalid at %0t: busy %b, faults %b%b%b", $time,
                         req_busy, fault_load_page, fault_store_page, fault_insn_page);
                n_errors++;
            end
        end
    end

    function automatic tlb_pkg::pte_t make_pte(input logic v, input logic r, input logic w,
                                               input logic x, input logic u, input logic g);
        tlb_pkg::pte_t pte;
        pte                  = '0;
        pte.ppn              = `TLB_PPN_BITS'($urandom);
        pte.perms.valid      = v;
        pte.perms.readable   = r;
        pte.perms.writable   = w;
        pte.perms.executable = x;
        pte.perms.user       = u;
        pte.perms.global_page = g;
        return pte;
    endfunction

    // sv32 page fault rule giving {load, store, insn}
    function automatic logic [2:0] expect_faults(input tlb_pkg::pte_t pte,
                                                 input tlb_pkg::access_e kind,
                                                 input logic umode);
        logic bad;
        bad = !pte.perms.valid || (pte.perms.writable && !pte.perms.readable) ||
              (pte.perms.user != umode);
        case (kind)
            tlb_pkg::LOAD:  bad = bad || !pte.perms.readable;
            tlb_pkg::STORE: bad = bad || !pte.perms.writable;
            tlb_pkg::INSN:  bad = bad || !pte.perms.executable;
            default:        bad = 1'b0;
        endcase
        return {bad && kind == tlb_pkg::LOAD, bad && kind == tlb_pkg::STORE,
                bad && kind == tlb_pkg::INSN};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        n_checks++;
        assert (ok) else begin
            $display("%s", what);
            n_errors++;
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        if (n_errors == test_errors) begin
            $display("test %0d %s: ok", n_tests, test_name);
        end else begin
            $display("test %0d %s: %0d errors", n_tests, test_name, n_errors - test_errors);
        end
    endtask

    task automatic load_pte(input int idx, input tlb_pkg::pte_t pte);
        @(negedge CLK);
        pt_we       = 1'b1;
        pt_index    = `PT_INDEX_BITS'(idx);
        pt_pte      = pte;
        shadow[idx] = pte;
        @(negedge CLK);
        pt_we = 1'b0;
    endtask

    // one request held until busy drops and then checked against the shadow table
    task automatic translate(input logic [31:0] va, input tlb_pkg::access_e kind,
                             input logic exp_miss);
        tlb_pkg::pte_t           pte;
        logic [`TLB_PA_BITS-1:0] exp_pa;
        logic [2:0]              exp_faults;
        logic                    seen_miss;
        int                      n;
        pte = shadow[va[`TLB_OFFSET_BITS +: `PT_INDEX_BITS]];
        if (addr_trans_on) begin
            exp_pa     = {pte.ppn, va[`TLB_OFFSET_BITS-1:0]};
            exp_faults = expect_faults(pte, kind, user_mode);
        end else begin
            exp_pa     = `TLB_PA_BITS'(va); // zero extended
            exp_faults = 3'b000;
        end
        @(negedge CLK);
        req_addr = va;
        req_ren  = (kind == tlb_pkg::LOAD);
        req_wen  = (kind == tlb_pkg::STORE);
        req_exec = (kind == tlb_pkg::INSN);
        #1;
        seen_miss = tlb_miss;
        n         = 0;
        while (req_busy && n < TIMEOUT) begin
            @(negedge CLK);
            #1;
            seen_miss = seen_miss | tlb_miss;
            n++;
        end
        if (req_busy) begin
            timeout_fail($sformatf("request at va %h never completed", va));
        end else begin
            check_val("resp_pa", 64'(resp_pa), 64'(exp_pa));
            check_val("fault_load_page", 64'(fault_load_page), 64'(exp_faults[2]));
            check_val("fault_store_page", 64'(fault_store_page), 64'(exp_faults[1]));
            check_val("fault_insn_page", 64'(fault_insn_page), 64'(exp_faults[0]));
            check_val("tlb_miss", 64'(seen_miss), 64'(exp_miss));
            if (!exp_miss) begin
                check_true(n == 0, $sformatf("hit at va %h took %0d extra cycles", va, n));
            end
            @(negedge CLK); // let the hit update the replacement bit
            req_ren  = 1'b0;
            req_wen  = 1'b0;
            req_exec = 1'b0;
        end
    endtask

    task automatic run_fence(input logic [31:0] va, input logic [`TLB_ASID_BITS-1:0] asid);
        int start_count;
        int n;
        start_count = done_count;
        @(negedge CLK);
        fence      = 1'b1;
        fence_va   = va;
        fence_asid = asid;
        @(negedge CLK);
        fence = 1'b0;
        #1;
        n = 0;
        while (done_count == start_count && n < TIMEOUT) begin
            @(negedge CLK);
            #1;
            n++;
        end
        if (done_count == start_count) begin
            timeout_fail("fence_done never pulsed after a fence");
        end else begin
            repeat (4) @(negedge CLK);
            fence_va   = '0;
            fence_asid = '0;
            #1;
            check_true(done_count - start_count == 1,
                       $sformatf("fence_done pulsed %0d times for one fence",
                                 done_count - start_count));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        nRST          = 1'b0;
        req_addr      = '0;
        req_ren       = 1'b0;
        req_wen       = 1'b0;
        req_exec      = 1'b0;
        satp_asid     = 9'd1;
        user_mode     = 1'b0;
        addr_trans_on = 1'b0;
        fence         = 1'b0;
        fence_va      = '0;
        fence_asid    = '0;
        pt_we         = 1'b0;
        pt_index      = '0;
        pt_pte        = '0;
        n_checks      = 0;
        n_errors      = 0;
        n_tests       = 0;
        done_count    = 0;
        for (int i = 0; i < `PT_ENTRIES; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(negedge CLK);
        nRST = 1'b1;

        // loading outlasts the reset sweep
        // pte flags given as v r w x u g
        load_pte(1, make_pte(1, 1, 1, 1, 0, 0));
        load_pte(2, make_pte(1, 1, 0, 0, 0, 0)); // read only
        load_pte(3, make_pte(1, 0, 0, 1, 0, 0)); // execute only
        load_pte(4, make_pte(0, 1, 1, 1, 0, 0)); // invalid
        load_pte(5, make_pte(1, 1, 1, 1, 1, 0)); // user page
        load_pte(6, make_pte(1, 1, 1, 1, 0, 1)); // global
        load_pte(7, make_pte(1, 1, 1, 1, 0, 0));
        load_pte(15, make_pte(1, 1, 1, 1, 0, 0));
        load_pte(23, make_pte(1, 1, 1, 1, 0, 0));

        start_test("miss then hit");
        translate(32'h1234_5678, tlb_pkg::LOAD, 1'b0); // pass through
        translate(32'hfedc_ba98, tlb_pkg::STORE, 1'b0);
        addr_trans_on = 1'b1;
        translate(VA_RWX, tlb_pkg::LOAD, 1'b1);
        translate(VA_RWX, tlb_pkg::LOAD, 1'b0);
        translate(VA_RWX, tlb_pkg::STORE, 1'b0);
        translate(VA_RWX, tlb_pkg::INSN, 1'b0);
        end_test();

        start_test("permission faults");
        translate(VA_RO, tlb_pkg::LOAD, 1'b1);
        translate(VA_RO, tlb_pkg::STORE, 1'b0);
        translate(VA_RO, tlb_pkg::INSN, 1'b0);
        translate(VA_XO, tlb_pkg::LOAD, 1'b1);
        translate(VA_XO, tlb_pkg::INSN, 1'b0);
        translate(VA_INV, tlb_pkg::LOAD, 1'b1);
        translate(VA_USR, tlb_pkg::LOAD, 1'b1); // supervisor on a user page
        user_mode = 1'b1;
        translate(VA_USR, tlb_pkg::STORE, 1'b0);
        translate(VA_RWX, tlb_pkg::LOAD, 1'b0); // user on a supervisor page
        user_mode = 1'b0;
        end_test();

        start_test("asid tagging");
        satp_asid = 9'd2;
        translate(VA_RWX, tlb_pkg::LOAD, 1'b1);
        translate(VA_RWX, tlb_pkg::LOAD, 1'b0);
        satp_asid = 9'd1;
        translate(VA_RWX, tlb_pkg::LOAD, 1'b0); // both asids share the set
        end_test();

        start_test("fence");
        run_fence(VA_RWX, 9'd0);
        translate(VA_RWX, tlb_pkg::LOAD, 1'b1);
        translate(VA_RO, tlb_pkg::LOAD, 1'b0);
        translate(VA_GLB, tlb_pkg::LOAD, 1'b1);
        run_fence(32'h0, 9'd1);
        translate(VA_GLB, tlb_pkg::LOAD, 1'b0);
        translate(VA_RO, tlb_pkg::LOAD, 1'b1);
        end_test();

        start_test("replacement");
        translate(VA_A, tlb_pkg::LOAD, 1'b1);
        translate(VA_B, tlb_pkg::LOAD, 1'b1);
        translate(VA_A, tlb_pkg::LOAD, 1'b0);
        translate(VA_C, tlb_pkg::LOAD, 1'b1); // B was used least recently
        translate(VA_A, tlb_pkg::LOAD, 1'b0);
        translate(VA_B, tlb_pkg::LOAD, 1'b1);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+.
tlb_pkg.sv
tlb_bus_if.sv
tlb_set_ram.sv
page_perm_check.sv
tlb.sv
page_table_mem.sv
tlb_top.sv
tb_tlb_top.sv
